//--- testbench/awp_tests.txt
// Each line is a kind digit followed by 16 hex digits of value
// Kind 1 is an ingress word in the low 16 bits, kind 2 the next expected egress word
// Weights 1 2 3 4 into quads 0 to 3, weight sum 10
10000000000000001
10000000000001002
10000000000002003
10000000000003004
// Pixels 1 to 4
10000000000004001
10000000000004002
10000000000004003
10000000000004004
20028001E0014000A
// Burst of pixels 0x10 to 0x2B, seven full words
10000000000004010
10000000000004011
10000000000004012
10000000000004013
200BE00B400AA00A0
10000000000004014
10000000000004015
10000000000004016
10000000000004017
200E600DC00D200C8
10000000000004018
10000000000004019
1000000000000401A
1000000000000401B
2010E010400FA00F0
1000000000000401C
1000000000000401D
1000000000000401E
1000000000000401F
20136012C01220118
10000000000004020
10000000000004021
10000000000004022
10000000000004023
2015E0154014A0140
10000000000004024
10000000000004025
10000000000004026
10000000000004027
20186017C01720168
10000000000004028
10000000000004029
1000000000000402A
1000000000000402B
201AE01A4019A0190
// Flush with nothing pending
10000000000008000
// Pixel 5 with reserved bits set, reserved op, pixel 6 with tag 3, flush
10000000000004F05
1000000000000CF5A
10000000000007006
10000000000008000
200000000003C0032
// Pixel 7, quad 2 reloaded to 0xFF, then pixels 7 and 0xFF, flush
10000000000004007
100000000000020FF
10000000000004007
100000000000040FF
10000000000008000
2000004FA072A0046
// Trailing items with no output
1000000000000C0AA
10000000000008000
1000000000000C055

//--- verilog.f
common/awp_cfg_pkg.sv
common/awp_op_pkg.sv
common/cascade_if.sv
hdl/fifo_fwft.sv
quad/awp_quad.sv
hdl/convmap_packer.sv
hdl/cnn_layer_accel_awp.sv
testbench/tb_awp.sv

//--- Makefile
# Verilator build and run of the accelerator testbench

TOP     = tb_awp
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_awp.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the accelerator wrapper
////////////////////////////////////////////////////////////////////////////
module tb_awp import awp_cfg_pkg::*;;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_LINES    = 256;
    // Egress hold-off after reset that fills both FIFOs
    localparam int FILL_CYCLES  = 150;
    // Watchdog budget per data line
    localparam int CYCLES_PER_LINE = 200;

    logic                clk_intf;
    logic                rst;
    logic                in_vld;
    logic                in_rdy;
    logic [IN_WIDTH-1:0] in_data;
    logic                out_vld;
    logic                out_rdy;
    logic [EG_WIDTH-1:0] out_data;

    // Kind nibble above a 64-bit value
    logic [EG_WIDTH+3:0] test_mem [MAX_LINES];
    logic [IN_WIDTH-1:0] in_words [$];
    logic [EG_WIDTH-1:0] exp_words [$];
    int                  n_lines;
    int                  n_exp;
    int                  exp_idx;
    int                  errors;
    bit                  loaded;
    integer              seed = 80;

    cnn_layer_accel_awp cnn_layer_accel_awp_inst (
        .clk_intf ( clk_intf ),
        .rst      ( rst      ),
        .in_vld   ( in_vld   ),
        .in_rdy   ( in_rdy   ),
        .in_data  ( in_data  ),
        .out_vld  ( out_vld  ),
        .out_rdy  ( out_rdy  ),
        .out_data ( out_data )
    );

    initial begin
        clk_intf = 1'b0;
        forever #(CLK_PERIOD / 2) clk_intf = ~clk_intf;
    end

    // Compare a DUT output with its expected value
    task automatic check_value(input string name, input logic [EG_WIDTH-1:0] actual,
                               input logic [EG_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // Split data lines into ingress words and expected egress words
    task automatic load_tests();
        logic [3:0] kind;
        for (int i = 0; i < MAX_LINES; i++) begin
            test_mem[i] = '0;
        end
        $readmemh("testbench/awp_tests.txt", test_mem);
        for (int i = 0; i < MAX_LINES; i++) begin
            kind = test_mem[i][EG_WIDTH +: 4];
            if (kind == 4'd1) begin
                in_words.push_back(test_mem[i][IN_WIDTH-1:0]);
                n_lines++;
            end else if (kind == 4'd2) begin
                exp_words.push_back(test_mem[i][EG_WIDTH-1:0]);
                n_lines++;
            end else if (kind != 4'd0) begin
                $display("Data line %0d has unknown kind %0d", i, kind);
                errors++;
            end
        end
    endtask

    // Starts 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_word(input logic [IN_WIDTH-1:0] word);
        logic taken;
        taken   = 1'b0;
        in_vld  = 1'b1;
        in_data = word;
        while (!taken) begin
            // in_rdy only moves on edges
            taken = in_rdy;
            @(posedge clk_intf);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst     = 1'b1;
        in_vld  = 1'b0;
        in_data = '0;
        out_rdy = 1'b0;
        errors  = 0;
        exp_idx = 0;
        n_lines = 0;
        load_tests();
        n_exp  = exp_words.size();
        loaded = 1'b1;
        if (in_words.size() == 0 || n_exp == 0) begin
            $display("Test file gave no ingress words or no expected words");
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk_intf);
        #1;
        rst = 1'b0;
        // Idle state straight out of reset
        check_value("out_vld", EG_WIDTH'(out_vld), EG_WIDTH'(0));
        check_value("in_rdy", EG_WIDTH'(in_rdy), EG_WIDTH'(1));
        foreach (in_words[i]) begin
            send_word(in_words[i]);
        end
        in_vld = 1'b0;
        wait (exp_idx == n_exp);
        // Time for a stray word to reach egress
        repeat (20) @(posedge clk_intf);
        #1;
        if (out_vld) begin
            $display("Egress FIFO still holds a word after all expected words arrived");
            errors++;
        end
        $display("Errors: %0d, egress words checked: %0d of %0d", errors, exp_idx, n_exp);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Random egress throttle with long low stretches
    initial begin
        int          stall_left;
        logic [31:0] r;
        stall_left = 0;
        repeat (RESET_CYCLES + FILL_CYCLES) @(posedge clk_intf);
        forever begin
            #1;
            if (stall_left > 0) begin
                out_rdy = 1'b0;
                stall_left--;
            end else begin
                r = $random(seed);
                if (r[4:0] == 5'd0) begin
                    stall_left = 20 + int'(r[10:5]);
                    out_rdy    = 1'b0;
                end else begin
                    out_rdy = r[5] | r[6];
                end
            end
            @(posedge clk_intf);
        end
    end

    // Handshake is stable at the falling edge and the word moves on the next rise
    always @(negedge clk_intf) begin
        if (!rst && out_vld && out_rdy) begin
            if (exp_idx >= n_exp) begin
                $display("Word %h arrived at %0t after all expected words were used",
                         out_data, $time);
                errors++;
            end else begin
                check_value("out_data", out_data, exp_words[exp_idx]);
                exp_idx++;
            end
        end
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk_intf);
        $display("Run timed out, only %0d of %0d expected words arrived", exp_idx, n_exp);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_awp

`default_nettype wire

//--- hdl/cnn_layer_accel_awp.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Accelerator wrapper, FIFOs around a quad chain
////////////////////////////////////////////////////////////////////////////
module cnn_layer_accel_awp import awp_cfg_pkg::*, awp_op_pkg::*; (
    input  wire logic                clk_intf,
    input  wire logic                rst,
    // Ingress
    input  wire logic                in_vld,
    output logic                     in_rdy,
    input  wire logic [IN_WIDTH-1:0] in_data,
    // Egress
    output logic                     out_vld,
    input  wire logic                out_rdy,
    output logic [EG_WIDTH-1:0]      out_data
);

    logic                in_wren;
    logic                in_rden;
    logic [IN_WIDTH-1:0] in_dout;
    logic                in_empty;
    logic                in_full;

    logic                eg_wren;
    logic                eg_rden;
    logic [EG_WIDTH-1:0] eg_din;
    logic                eg_empty;
    logic                eg_full;

    // Chain links, stage 0 is the ingress FIFO head
    cascade_if casc [NUM_QUADS+1] ();

    // Outside handshakes
    assign in_rdy  = !in_full;
    assign in_wren = in_vld && in_rdy;
    assign out_vld = !eg_empty;
    assign eg_rden = out_vld && out_rdy;

    fifo_fwft #(
        .DATA_WIDTH ( IN_WIDTH   ),
        .DEPTH      ( FIFO_DEPTH )
    ) in_fifo_inst (
        .clk_intf ( clk_intf ),
        .rst      ( rst      ),
        .wren     ( in_wren  ),
        .rden     ( in_rden  ),
        .datain   ( in_data  ),
        .dataout  ( in_dout  ),
        .empty    ( in_empty ),
        .full     ( in_full  )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stage 0 decode of the ingress word
    ////////////////////////////////////////////////////////////////////////////
    assign casc[0].valid = !in_empty;
    assign casc[0].op    = awp_op_t'(in_dout[OP_MSB:OP_LSB]);
    assign casc[0].tag   = in_dout[TAG_MSB:TAG_LSB];
    assign casc[0].pix   = in_dout[DATA_MSB:DATA_LSB];
    // Chain starts from a zero sum
    assign casc[0].psum  = '0;
    assign in_rden       = casc[0].ready;

    // Quad k reads link k, drives link k+1
    for (genvar gi = 0; gi < NUM_QUADS; gi++) begin : g_quad
        awp_quad #(
            .QUAD_INDEX ( gi )
        ) quad_inst (
            .clk_intf ( clk_intf     ),
            .rst      ( rst          ),
            .up       ( casc[gi]     ),
            .down     ( casc[gi + 1] )
        );
    end

    convmap_packer packer_inst (
        .clk_intf ( clk_intf        ),
        .rst      ( rst             ),
        .res      ( casc[NUM_QUADS] ),
        .eg_wren  ( eg_wren         ),
        .eg_data  ( eg_din          ),
        .eg_full  ( eg_full         )
    );

    fifo_fwft #(
        .DATA_WIDTH ( EG_WIDTH   ),
        .DEPTH      ( FIFO_DEPTH )
    ) eg_fifo_inst (
        .clk_intf ( clk_intf ),
        .rst      ( rst      ),
        .wren     ( eg_wren  ),
        .rden     ( eg_rden  ),
        .datain   ( eg_din   ),
        .dataout  ( out_data ),
        .empty    ( eg_empty ),
        .full     ( eg_full  )
    );

endmodule : cnn_layer_accel_awp

`default_nettype wire

//--- hdl/convmap_packer.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Packs last-quad results into egress words
////////////////////////////////////////////////////////////////////////////
module convmap_packer import awp_cfg_pkg::*, awp_op_pkg::*; (
    input  wire logic                clk_intf,
    input  wire logic                rst,
    cascade_if.consumer              res,
    output logic                     eg_wren,
    output logic [EG_WIDTH-1:0]      eg_data,
    input  wire logic                eg_full
);

    // Filled slots, lowest slot first
    logic [PSUM_WIDTH-1:0]     slot_q [RESULTS_PER_WORD];
    logic [SLOT_IDX_WIDTH-1:0] slot_cnt;
    logic                      take;
    logic                      take_pix;
    logic                      take_flush;
    logic                      word_done;

    // Stall the chain while egress is full
    assign res.ready = !eg_full;
    assign take      = res.valid && res.ready;

    assign take_pix   = take && (res.op == OP_PIXEL);
    assign take_flush = take && (res.op == OP_FLUSH);

    // Pixel landing in the top slot
    assign word_done = take_pix && (slot_cnt == SLOT_IDX_WIDTH'(RESULTS_PER_WORD - 1));

    // Empty flush writes nothing
    assign eg_wren = word_done || (take_flush && (slot_cnt != '0));

    ////////////////////////////////////////////////////////////////////////////
    // Egress word assembly
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        eg_data = '0;
        for (int i = 0; i < RESULTS_PER_WORD; i++) begin
            if (SLOT_IDX_WIDTH'(i) < slot_cnt) begin
                eg_data[i*PSUM_WIDTH +: PSUM_WIDTH] = slot_q[i];
            end else if (take_pix && (SLOT_IDX_WIDTH'(i) == slot_cnt)) begin
                // Result arriving this edge
                eg_data[i*PSUM_WIDTH +: PSUM_WIDTH] = res.psum;
            end
        end
    end

    // Slot storage
    always_ff @(posedge clk_intf) begin
        if (take_pix) begin
            slot_q[slot_cnt] <= res.psum;
        end
    end

    // Slot count, back to zero on word or flush
    always_ff @(posedge clk_intf) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (word_done || take_flush) begin
            slot_cnt <= '0;
        end else if (take_pix) begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

endmodule : convmap_packer

`default_nettype wire

//--- quad/awp_quad.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Processing quad with one weight and a one-entry output register
////////////////////////////////////////////////////////////////////////////
module awp_quad import awp_cfg_pkg::*, awp_op_pkg::*; #(
    parameter int QUAD_INDEX = 0
) (
    input  wire logic  clk_intf,
    input  wire logic  rst,
    cascade_if.consumer up,
    cascade_if.producer down
);

    logic [PIXEL_WIDTH-1:0] weight;
    logic [PSUM_WIDTH-1:0]  product;
    logic                   accept;
    logic                   my_load;

    // Take a new item when the output slot frees up this edge
    assign up.ready = !down.valid || down.ready;
    assign accept   = up.valid && up.ready;

    // Weight load addressed to this quad
    assign my_load = accept && (up.op == OP_LOAD_WEIGHT)
                     && (up.tag == QUAD_ID_WIDTH'(QUAD_INDEX));

    // Full-width product, wraps with the sum
    assign product = PSUM_WIDTH'(weight) * PSUM_WIDTH'(up.pix);

    always_ff @(posedge clk_intf) begin
        if (rst) begin
            weight <= '0;
        end else if (my_load) begin
            weight <= up.pix;
        end
    end

    // Output valid
    always_ff @(posedge clk_intf) begin
        if (rst) begin
            down.valid <= 1'b0;
        end else if (accept) begin
            down.valid <= 1'b1;
        end else if (down.ready) begin
            down.valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output payload, every item forwarded
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_intf) begin
        if (accept) begin
            down.op  <= up.op;
            down.tag <= up.tag;
            down.pix <= up.pix;
            // Only pixels accumulate
            down.psum <= (up.op == OP_PIXEL) ? up.psum + product : up.psum;
        end
    end

endmodule : awp_quad

`default_nettype wire

//--- hdl/fifo_fwft.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// First-word-fall-through FIFO
////////////////////////////////////////////////////////////////////////////
module fifo_fwft #(
    parameter int DATA_WIDTH = 16,
    parameter int DEPTH      = 8
) (
    input  wire logic                  clk_intf,
    input  wire logic                  rst,
    input  wire logic                  wren,
    input  wire logic                  rden,
    input  wire logic [DATA_WIDTH-1:0] datain,
    output logic      [DATA_WIDTH-1:0] dataout,
    output logic                       empty,
    output logic                       full
);

    // Word storage
    logic [DATA_WIDTH-1:0]        mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH)-1:0]     last_idx;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         do_wr;
    logic                         do_rd;

    // Pointer wrap point
    assign last_idx = DEPTH[$clog2(DEPTH)-1:0] - 1'b1;

    assign empty = (count == '0);
    assign full  = (count == DEPTH[$clog2(DEPTH+1)-1:0]);

    // Drop writes when full, reads when empty
    assign do_wr = wren && !full;
    assign do_rd = rden && !empty;

    // Head word always visible
    assign dataout = mem[rd_ptr];

    always_ff @(posedge clk_intf) begin
        if (do_wr) begin
            mem[wr_ptr] <= datain;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_intf) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leave count as is
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : fifo_fwft

`default_nettype wire

//--- common/cascade_if.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// One item between chain stages, valid/ready handshake
////////////////////////////////////////////////////////////////////////////
interface cascade_if import awp_cfg_pkg::*, awp_op_pkg::*; ();

    logic                      valid;
    logic                      ready;
    awp_op_t                   op;
    logic [QUAD_ID_WIDTH-1:0]  tag;
    // Pixel or weight value
    logic [PIXEL_WIDTH-1:0]    pix;
    // Running sum, grows at each quad
    logic [PSUM_WIDTH-1:0]     psum;

    // Upstream side of a link
    modport producer (output valid, output op, output tag, output pix, output psum,
                      input ready);

    // Downstream side of a link
    modport consumer (input valid, input op, input tag, input pix, input psum,
                      output ready);

endinterface : cascade_if

`default_nettype wire

//--- common/awp_op_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Transaction opcodes and ingress word layout
////////////////////////////////////////////////////////////////////////////
package awp_op_pkg;

    // Opcode carried with every item down the chain
    typedef enum logic [1:0] {
        OP_LOAD_WEIGHT = 2'd0,  // Weight for the tagged quad
        OP_PIXEL       = 2'd1,  // Pixel through all quads
        OP_FLUSH       = 2'd2,  // Push out a partial egress word
        OP_RESERVED    = 2'd3   // Forwarded, no effect
    } awp_op_t;

    // Ingress word fields, bits 11..8 unused
    localparam int OP_MSB   = 15;
    localparam int OP_LSB   = 14;
    localparam int TAG_MSB  = 13;
    localparam int TAG_LSB  = 12;
    localparam int DATA_MSB = 7;
    localparam int DATA_LSB = 0;

endpackage : awp_op_pkg

`default_nettype wire

//--- common/awp_cfg_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Accelerator sizing
////////////////////////////////////////////////////////////////////////////
package awp_cfg_pkg;

    // Quad chain length and tag width
    localparam int NUM_QUADS        = 4;
    localparam int QUAD_ID_WIDTH    = 2;

    // Pixel and weight share one width, unsigned
    localparam int PIXEL_WIDTH      = 8;

    // Partial sum wraps modulo 2^PSUM_WIDTH
    localparam int PSUM_WIDTH       = 16;

    // Ingress and egress word widths
    localparam int IN_WIDTH         = 16;
    localparam int EG_WIDTH         = 64;

    // Result slots per egress word
    localparam int RESULTS_PER_WORD = EG_WIDTH / PSUM_WIDTH;
    // Slot index inside the packer
    localparam int SLOT_IDX_WIDTH   = $clog2(RESULTS_PER_WORD);

    // Ingress and egress FIFO depth
    localparam int FIFO_DEPTH       = 8;

endpackage : awp_cfg_pkg

`default_nettype wire
